/* hdl/tcm_pkg.sv */
/*
 Shared widths, AXI4-Lite channel payloads and enums for the TCM.
 Bus is fixed at 32 data bits; SRAM rows may be 32, 64 or 128 bits wide.
 undef_pattern covers at most row_w_max bits.
*/
package tcm_pkg;

   localparam int axil_addr_w = 32;
   localparam int axil_data_w = 32;
   localparam int axil_strb_w = axil_data_w / 8;  // One strobe per byte
   localparam int row_w_max   = 128;              // Widest supported SRAM row

   // AXI response codes, only the two this target returns
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axil_resp_e;

   typedef enum logic [1:0] {
      st_idle,     // Waiting for AW+W or AR
      st_rd_data,  // SRAM read data valid this cycle
      st_b_resp,   // Write response pending
      st_r_resp    // Read response pending
   } tcm_state_e;

   typedef struct packed {
      logic [axil_addr_w-1:0] addr;
      logic [2:0]             prot;  // Not used by the TCM
   } axil_aw_t;

   typedef axil_aw_t axil_ar_t;      // Same fields as AW

   typedef struct packed {
      logic [axil_data_w-1:0] data;
      logic [axil_strb_w-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      axil_resp_e resp;
   } axil_b_t;

   typedef struct packed {
      logic [axil_data_w-1:0] data;
      axil_resp_e             resp;
   } axil_r_t;

   // Word request, slave to lane window
   typedef struct packed {
      logic                   re;
      logic [axil_strb_w-1:0] we;         // Byte enables, zero when no write
      logic [axil_addr_w-1:0] word_addr;  // Word index, trimmed in the window
      logic [axil_data_w-1:0] wdata;
   } sram_req_t;

   // Alternating 01 pairs in the low width bits, upper bits zero
   function automatic logic [row_w_max-1:0] undef_pattern(input int unsigned width);
      logic [row_w_max-1:0] p;
      p = '0;
      for (int i = 0; i < row_w_max; i += 2)
      begin
         if (i < width)
            p[i] = 1'b1;
      end
      return p;
   endfunction

endpackage

/* hdl/spram_be.sv */
/*
 Behavioral single-port SRAM with byte write enables.
 Read data appears one cycle after re and holds until the next re.
 In the cycle after any write the output shows a fixed 0101.. pattern,
 as a hard macro would, so callers must not sample there.
*/
`timescale 1ns/1ns

module spram_be import tcm_pkg::*;
#(
   parameter int ROW_W  = 64,
   parameter int ROW_AW = 8
)
(
   input  logic                 CLK,
   input  logic [ROW_AW-1:0]    addr,
   input  logic                 re,
   input  logic [ROW_W/8-1:0]   we,
   input  logic [ROW_W-1:0]     din,
   output logic [ROW_W-1:0]     dout
);

   localparam int n_bytes = ROW_W / 8;
   localparam int n_rows  = 2 ** ROW_AW;
   localparam logic [row_w_max-1:0] undef_full = undef_pattern(ROW_W);

   logic [ROW_W-1:0] mem [n_rows];  // Row storage
   logic [ROW_W-1:0] rd_q;          // Output latch of the macro
   logic             we_q;          // Write happened last cycle

   // Byte-wise write port
   always_ff @(posedge CLK)
   begin
      for (int b = 0; b < n_bytes; b++)
      begin
         if (we[b])
            mem[addr][b*8 +: 8] <= din[b*8 +: 8];
      end
   end

   // Read register, loaded only on re
   always_ff @(posedge CLK)
   begin
      if (re)
         rd_q <= mem[addr];
   end

   // Remember a write cycle to corrupt the next output
   always_ff @(posedge CLK)
   begin
      we_q <= |we;
   end

   // Cell output is not reliable right after a write
   assign dout = we_q ? undef_full[ROW_W-1:0] : rd_q;

endmodule

/* hdl/sram_lane_window.sv */
/*
 Maps 32-bit word requests onto SRAM rows of ROW_W bits.
 Low word-index bits pick the lane, the rest the row; upper bits are dropped,
 so range checks belong upstream. Request path is combinational.
*/
`timescale 1ns/1ns

module sram_lane_window import tcm_pkg::*;
#(
   parameter int ROW_W  = 64,
   parameter int ROW_AW = 8
)
(
   input  logic                   CLK,
   input  logic                   rst,
   input  sram_req_t              req,
   output logic [axil_data_w-1:0] rdata,
   output logic                   ram_re,
   output logic [ROW_W/8-1:0]     ram_we,
   output logic [ROW_AW-1:0]      ram_addr,
   output logic [ROW_W-1:0]       ram_din,
   input  logic [ROW_W-1:0]       ram_dout
);

   localparam int lanes     = ROW_W / axil_data_w;
   localparam int lane_sh   = $clog2(lanes);              // 0 for a single lane
   localparam int lane_bits = (lanes > 1) ? lane_sh : 1;  // Keep a legal width
   localparam int word_aw   = ROW_AW + lane_sh;

   logic [word_aw-1:0]   word_idx;
   logic [lane_bits-1:0] lane;    // Lane of the current request
   logic [lane_bits-1:0] lane_q;  // Lane of the last read

   assign word_idx = req.word_addr[word_aw-1:0];  // Drop unused upper bits
   assign ram_addr = word_idx[word_aw-1 -: ROW_AW];
   assign ram_re   = req.re;

   generate
      if (lanes > 1)
      begin : g_multi
         assign lane = word_idx[lane_bits-1:0];
      end
      else
      begin : g_single
         assign lane = '0;  // Row is one word
      end
   endgenerate

   // Strobes land only in the selected lane, data goes to all lanes
   always_comb
   begin
      for (int l = 0; l < lanes; l++)
      begin
         ram_we[l*axil_strb_w +: axil_strb_w] = (lane == lane_bits'(l)) ? req.we : '0;
         ram_din[l*axil_data_w +: axil_data_w] = req.wdata;
      end
   end

   // Read lane follows the address of the read itself
   always_ff @(posedge CLK)
   begin
      if (rst)
         lane_q <= '0;
      else if (req.re)
         lane_q <= lane;
   end

   assign rdata = ram_dout[lane_q*axil_data_w +: axil_data_w];

endmodule

/* hdl/tcm_axil_slave.sv */
/*
 AXI4-Lite target for the TCM, one transaction in flight, no bursts.
 AW and W are taken together only; write wins over a same-cycle AR.
 Addresses at or past the memory size get SLVERR and touch no SRAM.
 AXPROT is ignored.
*/
`timescale 1ns/1ns

module tcm_axil_slave import tcm_pkg::*;
#(
   parameter int ROW_W  = 64,
   parameter int ROW_AW = 8
)
(
   input  logic                   CLK,
   input  logic                   rst,
   // Write address
   input  logic                   aw_valid,
   output logic                   aw_ready,
   input  axil_aw_t               aw,
   // Write data
   input  logic                   w_valid,
   output logic                   w_ready,
   input  axil_w_t                w,
   // Write response
   output logic                   b_valid,
   input  logic                   b_ready,
   output axil_b_t                b,
   // Read address
   input  logic                   ar_valid,
   output logic                   ar_ready,
   input  axil_ar_t               ar,
   // Read data
   output logic                   r_valid,
   input  logic                   r_ready,
   output axil_r_t                r,
   // SRAM side, through the lane window
   output sram_req_t              req,
   input  logic [axil_data_w-1:0] rdata
);

   localparam int word_aw = ROW_AW + $clog2(ROW_W / axil_data_w);
   // Memory size in bytes, 4 bytes per word
   localparam logic [63:0] mem_bytes = 64'd4 << word_aw;

   tcm_state_e state;
   axil_b_t    b_q;     // Held write response
   axil_r_t    r_q;     // Held read response

   logic wr_acc;        // AW and W handshake this cycle
   logic rd_acc;        // AR handshake this cycle
   logic aw_in_range;
   logic ar_in_range;

   // Range checks on the byte address
   assign aw_in_range = (64'(aw.addr) < mem_bytes);
   assign ar_in_range = (64'(ar.addr) < mem_bytes);

   // Accepts only in idle; write first
   assign wr_acc = (state == st_idle) && aw_valid && w_valid;
   assign rd_acc = (state == st_idle) && ar_valid && !(aw_valid && w_valid);

   assign aw_ready = wr_acc;  // Rise together with W
   assign w_ready  = wr_acc;
   assign ar_ready = rd_acc;

   // SRAM request, same cycle as the accept
   always_comb
   begin
      req.re    = rd_acc && ar_in_range;  // No read for a bad address
      req.we    = (wr_acc && aw_in_range) ? w.strb : '0;
      req.wdata = w.data;
      // Byte address to word index
      if (wr_acc)
         req.word_addr = {2'b00, aw.addr[axil_addr_w-1:2]};
      else
         req.word_addr = {2'b00, ar.addr[axil_addr_w-1:2]};
   end

   // Control FSM
   always_ff @(posedge CLK)
   begin
      if (rst)
      begin
         state <= st_idle;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (wr_acc)
                  state <= st_b_resp;       // SRAM write already done
               else if (rd_acc && ar_in_range)
                  state <= st_rd_data;      // Wait for SRAM latency
               else if (rd_acc)
                  state <= st_r_resp;       // Error read, no SRAM access
            end
            st_rd_data:
            begin
               state <= st_r_resp;
            end
            st_b_resp:
            begin
               if (b_ready)
                  state <= st_idle;
            end
            st_r_resp:
            begin
               if (r_ready)
                  state <= st_idle;
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Write response payload
   always_ff @(posedge CLK)
   begin
      if (wr_acc)
         b_q.resp <= aw_in_range ? resp_okay : resp_slverr;
   end

   // Read response payload
   always_ff @(posedge CLK)
   begin
      if (rd_acc && !ar_in_range)
      begin
         r_q.data <= '0;          // Error reads return zero
         r_q.resp <= resp_slverr;
      end
      else if (state == st_rd_data)
      begin
         r_q.data <= rdata;       // Selected lane of the SRAM row
         r_q.resp <= resp_okay;
      end
   end

   // Valids decode from state, payloads held until ready
   assign b_valid = (state == st_b_resp);
   assign r_valid = (state == st_r_resp);
   assign b       = b_q;
   assign r       = r_q;

endmodule

/* hdl/tcm_top.sv */
/*
 TCM top: AXI4-Lite slave, lane window and behavioral SRAM.
 ROW_W must be 32, 64 or 128; capacity is 2**ROW_AW rows.
*/
`timescale 1ns/1ns

module tcm_top import tcm_pkg::*;
#(
   parameter int ROW_W  = 64,
   parameter int ROW_AW = 8
)
(
   input  logic     CLK,
   input  logic     rst,
   input  logic     aw_valid,
   output logic     aw_ready,
   input  axil_aw_t aw,
   input  logic     w_valid,
   output logic     w_ready,
   input  axil_w_t  w,
   output logic     b_valid,
   input  logic     b_ready,
   output axil_b_t  b,
   input  logic     ar_valid,
   output logic     ar_ready,
   input  axil_ar_t ar,
   output logic     r_valid,
   input  logic     r_ready,
   output axil_r_t  r
);

   sram_req_t              req;       // Word request from the slave
   logic [axil_data_w-1:0] rdata;     // Selected read word
   logic                   ram_re;
   logic [ROW_W/8-1:0]     ram_we;
   logic [ROW_AW-1:0]      ram_addr;
   logic [ROW_W-1:0]       ram_din;
   logic [ROW_W-1:0]       ram_dout;

   tcm_axil_slave #(.ROW_W(ROW_W), .ROW_AW(ROW_AW)) tcm_axil_slave_inst (
      .CLK      (CLK),
      .rst      (rst),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .aw       (aw),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .w        (w),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .b        (b),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .ar       (ar),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .r        (r),
      .req      (req),
      .rdata    (rdata)
   );

   sram_lane_window #(.ROW_W(ROW_W), .ROW_AW(ROW_AW)) sram_lane_window_inst (
      .CLK      (CLK),
      .rst      (rst),
      .req      (req),
      .rdata    (rdata),
      .ram_re   (ram_re),
      .ram_we   (ram_we),
      .ram_addr (ram_addr),
      .ram_din  (ram_din),
      .ram_dout (ram_dout)
   );

   spram_be #(.ROW_W(ROW_W), .ROW_AW(ROW_AW)) spram_be_inst (
      .CLK  (CLK),
      .addr (ram_addr),
      .re   (ram_re),
      .we   (ram_we),
      .din  (ram_din),
      .dout (ram_dout)
   );

endmodule

/* testbench/tb_clk_gen.sv */
/*
 Clock and reset source for the TCM testbench.
 CLK period 10 ns, rst high for the first 5 rising edges.
*/
`timescale 1ns/1ns

module tb_clk_gen
(
   output logic CLK,
   output logic rst
);

   initial
   begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;  // 10 ns period
   end

   initial
   begin
      rst = 1'b1;
      repeat (5) @(posedge CLK);
      rst <= 1'b0;  // Released on an edge, synchronous to CLK
   end

endmodule

/* testbench/tcm_asserts.sv */
/*
 Concurrent checks on the TCM slave handshakes, bound into tcm_axil_slave.
 fail_count counts failed assertions over the run.
*/
`timescale 1ns/1ns

module tcm_asserts import tcm_pkg::*;
(
   input logic    CLK,
   input logic    rst,
   input logic    aw_valid,
   input logic    aw_ready,
   input logic    w_ready,
   input logic    b_valid,
   input logic    b_ready,
   input axil_b_t b,
   input logic    ar_valid,
   input logic    ar_ready,
   input logic    r_valid,
   input logic    r_ready,
   input axil_r_t r
);

   int unsigned fail_count = 0;  // Failed assertion count
   logic        seen_acc;        // Any AW or AR accepted since reset
   logic        pending;         // Accepted, response not yet taken

   always_ff @(posedge CLK)
   begin
      if (rst)
         seen_acc <= 1'b0;
      else if ((aw_valid && aw_ready) || (ar_valid && ar_ready))
         seen_acc <= 1'b1;
   end

   // Open transaction tracked from the bus handshakes only
   always_ff @(posedge CLK)
   begin
      if (rst)
         pending <= 1'b0;
      else if ((b_valid && b_ready) || (r_valid && r_ready))
         pending <= 1'b0;        // Response taken
      else if ((aw_valid && aw_ready) || (ar_valid && ar_ready))
         pending <= 1'b1;
   end

   // No response before anything was accepted
   a_quiet_after_reset: assert property (@(posedge CLK) disable iff (rst)
      !seen_acc |-> !b_valid && !r_valid)
      else
      begin
         $error("Response valid before the first accept");
         fail_count++;
      end

   // Stalled responses hold their payloads
   a_b_stable: assert property (@(posedge CLK) disable iff (rst)
      b_valid && !b_ready |=> b_valid && $stable(b))
      else
      begin
         $error("B dropped or changed under stall");
         fail_count++;
      end

   a_r_stable: assert property (@(posedge CLK) disable iff (rst)
      r_valid && !r_ready |=> r_valid && $stable(r))
      else
      begin
         $error("R dropped or changed under stall");
         fail_count++;
      end

   // Nothing new while a transaction is open
   a_no_accept_pending: assert property (@(posedge CLK) disable iff (rst)
      pending |-> !aw_ready && !w_ready && !ar_ready)
      else
      begin
         $error("Ready high with a response pending");
         fail_count++;
      end

   a_r_latency: assert property (@(posedge CLK) disable iff (rst)
      ar_valid && ar_ready |-> ##[1:2] r_valid)
      else
      begin
         $error("r_valid late after AR accept");
         fail_count++;
      end

endmodule

bind tcm_axil_slave tcm_asserts tcm_asserts_inst (
   .CLK      (CLK),
   .rst      (rst),
   .aw_valid (aw_valid),
   .aw_ready (aw_ready),
   .w_ready  (w_ready),
   .b_valid  (b_valid),
   .b_ready  (b_ready),
   .b        (b),
   .ar_valid (ar_valid),
   .ar_ready (ar_ready),
   .r_valid  (r_valid),
   .r_ready  (r_ready),
   .r        (r)
);

/* testbench/tb_tcm.sv */
/*
 Trace-driven testbench for tcm_top with default ROW_W 64, ROW_AW 8 (2 KiB).
 Trace path is relative to the project root; stops at the first error.
 Valid delays and B/R stalls come from a fixed-seed LFSR.
*/
`timescale 1ns/1ns

module tb_tcm import tcm_pkg::*;
();

   logic     CLK;
   logic     rst;
   logic     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
   logic     ar_valid, ar_ready, r_valid, r_ready;
   axil_aw_t aw;
   axil_w_t  w;
   axil_b_t  b;
   axil_ar_t ar;
   axil_r_t  r;

   logic [31:0] lfsr = 32'h990b69c1;  // Stimulus randomness state

   tb_clk_gen tb_clk_gen_inst (.CLK(CLK), .rst(rst));

   tcm_top tcm_top_inst (.*);

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped on first error");
   endtask

   // Taps 32,22,2,1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output int unsigned v);
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = (v << 1) | lfsr[0];  // One step per bit
      end
   endtask

   task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t ns: %s got %s (%b) expected %s (%b)",
                        $time, name, got.name(), got, exp.name(), exp));
   endtask

   task automatic check_rdata(input string name, input logic [axil_data_w-1:0] got,
                              input logic [axil_data_w-1:0] exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                        $time, name, got, exp));
   endtask

   task automatic valid_delay();
      int unsigned d;
      take_bits(2, d);          // 0 to 3 cycles
      repeat (d) @(posedge CLK);
   endtask

   task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input axil_resp_e exp);
      int          n;
      int unsigned v;
      logic        done;
      valid_delay();
      aw_valid <= 1'b1;
      aw       <= '{addr: addr, prot: 3'b000};
      w_valid  <= 1'b1;
      w        <= '{data: data, strb: strb};
      n = 0;
      @(negedge CLK);
      while (!(aw_ready && w_ready))
      begin
         n++;
         if (n >= 50)
            report_failure($sformatf("Timeout waiting for aw_ready/w_ready, addr %h", addr));
         @(negedge CLK);
      end
      @(posedge CLK);           // Handshake edge
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      n = 0;
      done = 1'b0;
      while (!done)
      begin
         take_bits(1, v);
         b_ready <= v[0];       // Random stall
         @(negedge CLK);
         if (b_valid && b_ready)
         begin
            check_resp("b.resp", b.resp, exp);
            done = 1'b1;
         end
         else
         begin
            n++;
            if (n >= 50)
               report_failure($sformatf("Timeout waiting for b_valid, addr %h", addr));
         end
         @(posedge CLK);
      end
      b_ready <= 1'b0;
   endtask

   task automatic do_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input axil_resp_e exp);
      int          n;
      int unsigned v;
      logic        done;
      valid_delay();
      ar_valid <= 1'b1;
      ar       <= '{addr: addr, prot: 3'b000};
      n = 0;
      @(negedge CLK);
      while (!ar_ready)
      begin
         n++;
         if (n >= 50)
            report_failure($sformatf("Timeout waiting for ar_ready, addr %h", addr));
         @(negedge CLK);
      end
      @(posedge CLK);
      ar_valid <= 1'b0;
      n = 0;
      done = 1'b0;
      while (!done)
      begin
         take_bits(1, v);
         r_ready <= v[0];
         @(negedge CLK);
         if (r_valid && r_ready)
         begin
            check_resp("r.resp", r.resp, exp);
            check_rdata("r.data", r.data, exp_data);
            done = 1'b1;
         end
         else
         begin
            n++;
            if (n >= 50)
               report_failure($sformatf("Timeout waiting for r_valid, addr %h", addr));
         end
         @(posedge CLK);
      end
      r_ready <= 1'b0;
   endtask

   // Bound checker failures end the run at once
   always @(posedge CLK)
   begin
      if (tcm_top_inst.tcm_axil_slave_inst.tcm_asserts_inst.fail_count != 0)
         report_failure("A concurrent assertion failed during the run");
   end

   initial
   begin
      string       line;
      int          fd, code, cnt, kind, n;
      logic [31:0] addr, data, strb, resp;
      aw_valid = 1'b0;
      aw       = '0;
      w_valid  = 1'b0;
      w        = '0;
      b_ready  = 1'b0;
      ar_valid = 1'b0;
      ar       = '0;
      r_ready  = 1'b0;
      fd = $fopen("testbench/tcm_trace.txt", "r");
      if (fd == 0)
         report_failure("Cannot open testbench/tcm_trace.txt");
      n = 0;
      @(posedge CLK);
      while (rst)
      begin
         n++;
         if (n >= 50)
            report_failure("Timeout waiting for reset release");
         @(posedge CLK);
      end
      forever
      begin
         code = $fgets(line, fd);
         if (code == 0)
            break;              // End of trace
         if (line.len() < 3 || line[0] == "#")
            continue;           // Comment or blank
         if (line[0] == "W")
         begin
            cnt = $sscanf(line, "%c %h %h %h %h", kind, addr, data, strb, resp);
            if (cnt != 5)
               report_failure($sformatf("Malformed write line in trace: %s", line));
            do_write(addr, data, strb[3:0], axil_resp_e'(resp[1:0]));
         end
         else if (line[0] == "R")
         begin
            cnt = $sscanf(line, "%c %h %h %h", kind, addr, data, resp);
            if (cnt != 4)
               report_failure($sformatf("Malformed read line in trace: %s", line));
            do_read(addr, data, axil_resp_e'(resp[1:0]));
         end
         else
            report_failure($sformatf("Unknown kind in trace line: %s", line));
      end
      $fclose(fd);
      repeat (3) @(posedge CLK);  // Let the last assertions settle
      if (tcm_top_inst.tcm_axil_slave_inst.tcm_asserts_inst.fail_count != 0)
         report_failure("A concurrent assertion failed during the run");
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

/* testbench/tcm_trace.txt */
# W addr data strb resp : write, expected response (0 OKAY, 2 SLVERR)
# R addr data resp      : read, expected data and response; memory is 0x800 bytes
W 00000000 11223344 f 0
W 00000004 55667788 f 0
R 00000000 11223344 0
R 00000004 55667788 0
W 00000100 a5a5a5a5 f 0
R 00000100 a5a5a5a5 0
W 000007fc cafef00d f 0
R 000007fc cafef00d 0
# Partial strobes merge with old bytes
W 00000000 aabbccdd 1 0
R 00000000 112233dd 0
W 00000000 99887766 c 0
R 00000000 998833dd 0
W 00000004 0000ee00 2 0
R 00000004 5566ee88 0
R 00000000 998833dd 0
# Neighbor word in the same row
W 00000104 01020304 f 0
W 00000104 ffffffff 6 0
R 00000104 01ffff04 0
R 00000100 a5a5a5a5 0
# Out of range, aliases must stay untouched
W 00000800 deadbeef f 2
R 00000800 00000000 2
W 00000ffc 12345678 f 2
R 80000000 00000000 2
R 00000000 998833dd 0
R 000007fc cafef00d 0
# Reads right after writes
W 00000010 0badf00d f 0
R 00000010 0badf00d 0
W 00000014 13579bdf f 0
R 00000010 0badf00d 0
R 00000014 13579bdf 0
W 00000018 fedcba98 f 0
R 00000018 fedcba98 0
W 0000001c 76543210 f 0
R 0000001c 76543210 0
R 00000018 fedcba98 0

/* src.f */
hdl/tcm_pkg.sv
hdl/spram_be.sv
hdl/sram_lane_window.sv
hdl/tcm_axil_slave.sv
hdl/tcm_top.sv
testbench/tb_clk_gen.sv
testbench/tcm_asserts.sv
testbench/tb_tcm.sv

/* Bender.yml */
package:
  name: tcm

sources:
  - hdl/tcm_pkg.sv
  - hdl/spram_be.sv
  - hdl/sram_lane_window.sv
  - hdl/tcm_axil_slave.sv
  - hdl/tcm_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tcm_asserts.sv
      - testbench/tb_tcm.sv
